/* source/dnc_consts.svh */
`ifndef DNC_CONSTS_SVH
`define DNC_CONSTS_SVH

//////////////////////////////
// Vector element format
//////////////////////////////

// Signed Q16.16 element
`define DNC_DATA_WIDTH 32

// 1.0 in Q16.16
`define DNC_FX_ONE 32'h0001_0000

//////////////////////////////
// Vector length and buffer map
//////////////////////////////

// Longest key or erase vector
`define DNC_W_MAX 16

// Counter holds 0 to 16 inclusive
`define DNC_COUNT_WIDTH 5

// Two regions of DNC_W_MAX words each
`define DNC_ADDR_WIDTH 5
`define DNC_KEY_BASE 0
`define DNC_ERASE_BASE 16

`endif

/* source/dnc_pkg.sv */
`include "dnc_consts.svh"

package dnc_pkg;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  // One vector element, Q16.16
  typedef logic [`DNC_DATA_WIDTH-1:0] dnc_data_t;

  // Word address inside the vector buffer
  typedef logic [`DNC_ADDR_WIDTH-1:0] dnc_addr_t;

  // Vector length or element index
  typedef logic [`DNC_COUNT_WIDTH-1:0] dnc_count_t;

  //////////////////////////////
  // Buffer write request
  //////////////////////////////

  // Address in the upper bits, data below
  typedef struct packed {
    dnc_addr_t addr;
    dnc_data_t data;
  } buf_wr_t;

  //////////////////////////////
  // State machines
  //////////////////////////////

  // Sequencing shared by the key and erase writers
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ELEM,
    REQ,
    RELEASE
  } writer_state_t;

  // Buffer arbiter, idle or holding one ack
  typedef enum logic {
    ARB_IDLE,
    ARB_ACK
  } arb_state_t;

endpackage

/* source/dnc_write_key.sv */
`timescale 1ns/1ns
`include "dnc_consts.svh"

module dnc_write_key (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  dnc_pkg::dnc_count_t   size_w,
  input  logic                  k_in_enable,
  input  dnc_pkg::dnc_data_t    k_in,
  output logic                  k_in_ack,
  output logic                  k_out_valid,
  output dnc_pkg::dnc_data_t    k_out,
  output logic                  buf_req,
  output dnc_pkg::buf_wr_t      buf_wr,
  input  logic                  buf_ack,
  output logic                  ready
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  writer_state_t state;

  // Latched vector length and current element
  dnc_count_t size_q;
  dnc_count_t index;

  // Current element is the final one
  logic last_elem;

  //////////////////////////////
  // Handshake outputs
  //////////////////////////////

  // Element taken only while waiting for one
  assign k_in_ack = (state == WAIT_ELEM) && k_in_enable;

  // Request held for the whole REQ state
  assign buf_req = (state == REQ);

  // Mirror is the captured element itself
  assign k_out = buf_wr.data;

  assign last_elem = (index == (size_q - dnc_count_t'(1)));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE;
      size_q      <= '0;
      index       <= '0;
      ready       <= 1'b0;
      k_out_valid <= 1'b0;
    end else begin
      // Single-cycle strobes by default
      ready       <= 1'b0;
      k_out_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            size_q <= size_w;
            index  <= '0;
            state  <= WAIT_ELEM;
          end
        end
        WAIT_ELEM: begin
          // Capture cycle, mirror strobe follows
          if (k_in_enable) begin
            k_out_valid <= 1'b1;
            state       <= REQ;
          end
        end
        REQ: begin
          // Arbiter wrote the word
          if (buf_ack) begin
            state <= RELEASE;
          end
        end
        RELEASE: begin
          // Wait for ack to fall, closing phase four
          if (!buf_ack) begin
            if (last_elem) begin
              ready <= 1'b1;
              state <= IDLE;
            end else begin
              index <= index + dnc_count_t'(1);
              state <= WAIT_ELEM;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Captured request
  //////////////////////////////

  // Stable while buf_req is high
  always_ff @(posedge CLK) begin
    if (k_in_ack) begin
      buf_wr.addr <= dnc_addr_t'(`DNC_KEY_BASE) + dnc_addr_t'(index);
      buf_wr.data <= k_in;
    end
  end

  // Request only released once the arbiter has answered
  assert property (@(posedge CLK) disable iff (RST) $fell(buf_req) |-> buf_ack);

endmodule

/* source/dnc_erase_vector.sv */
`timescale 1ns/1ns
`include "dnc_consts.svh"

module dnc_erase_vector (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  dnc_pkg::dnc_count_t   size_w,
  input  logic                  e_in_enable,
  input  dnc_pkg::dnc_data_t    e_in,
  output logic                  e_in_ack,
  output logic                  buf_req,
  output dnc_pkg::buf_wr_t      buf_wr,
  input  logic                  buf_ack,
  output logic                  ready
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  writer_state_t state;

  dnc_count_t size_q;
  dnc_count_t index;
  logic       last_elem;

  // Element after saturation to [0, 1]
  dnc_data_t e_clamped;

  assign e_in_ack  = (state == WAIT_ELEM) && e_in_enable;
  assign buf_req   = (state == REQ);
  assign last_elem = (index == (size_q - dnc_count_t'(1)));

  //////////////////////////////
  // Saturating clamp
  //////////////////////////////

  // Stand-in for the erase sigmoid
  always_comb begin
    if (e_in[`DNC_DATA_WIDTH-1]) begin
      // Negative
      e_clamped = '0;
    end else if (e_in > dnc_data_t'(`DNC_FX_ONE)) begin
      e_clamped = dnc_data_t'(`DNC_FX_ONE);
    end else begin
      e_clamped = e_in;
    end
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= IDLE;
      size_q <= '0;
      index  <= '0;
      ready  <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            size_q <= size_w;
            index  <= '0;
            state  <= WAIT_ELEM;
          end
        end
        WAIT_ELEM: begin
          if (e_in_enable) begin
            state <= REQ;
          end
        end
        REQ: begin
          if (buf_ack) begin
            state <= RELEASE;
          end
        end
        RELEASE: begin
          // Next element only after ack drops
          if (!buf_ack) begin
            if (last_elem) begin
              ready <= 1'b1;
              state <= IDLE;
            end else begin
              index <= index + dnc_count_t'(1);
              state <= WAIT_ELEM;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Erase region word for this element
  always_ff @(posedge CLK) begin
    if (e_in_ack) begin
      buf_wr.addr <= dnc_addr_t'(`DNC_ERASE_BASE) + dnc_addr_t'(index);
      buf_wr.data <= e_clamped;
    end
  end

  // Whatever reaches the buffer is a valid erase weight
  assert property (@(posedge CLK) disable iff (RST)
    buf_req |-> (buf_wr.data <= dnc_data_t'(`DNC_FX_ONE)));

endmodule

/* source/dnc_buffer_arbiter.sv */
`timescale 1ns/1ns

module dnc_buffer_arbiter (
  input  logic               CLK,
  input  logic               RST,
  input  logic               req_key,
  input  logic               req_erase,
  input  dnc_pkg::buf_wr_t   wr_key,
  input  dnc_pkg::buf_wr_t   wr_erase,
  output logic               ack_key,
  output logic               ack_erase,
  output logic               mem_we,
  output dnc_pkg::buf_wr_t   mem_wr
);

  import dnc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  arb_state_t state;

  // Requester owning the port, 0 key and 1 erase
  logic sel;

  // Requester favoured on the next tie
  logic prio;

  // Winner if a grant happens this cycle
  logic pick;

  logic any_req;
  logic sel_req;

  //////////////////////////////
  // Grant choice
  //////////////////////////////

  assign any_req = req_key | req_erase;

  // Tie goes to the priority holder
  always_comb begin
    if (req_key && req_erase) begin
      pick = prio;
    end else begin
      pick = req_erase;
    end
  end

  // Request line of the current owner
  assign sel_req = sel ? req_erase : req_key;

  //////////////////////////////
  // Port outputs
  //////////////////////////////

  assign ack_key   = (state == ARB_ACK) && !sel;
  assign ack_erase = (state == ARB_ACK) && sel;

  // Owner data is held stable during its req
  assign mem_wr = sel ? wr_erase : wr_key;

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ARB_IDLE;
      sel    <= 1'b0;
      prio   <= 1'b0;
      mem_we <= 1'b0;
    end else begin
      // One write strobe per grant
      mem_we <= 1'b0;
      case (state)
        ARB_IDLE: begin
          if (any_req) begin
            sel    <= pick;
            prio   <= ~pick;
            mem_we <= 1'b1;
            state  <= ARB_ACK;
          end
        end
        ARB_ACK: begin
          // Owner lowered req, ack falls next
          if (!sel_req) begin
            state <= ARB_IDLE;
          end
        end
        default: begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  // Mutual exclusion of the acks
  assert property (@(posedge CLK) disable iff (RST) !(ack_key && ack_erase));

  // Acks only answer a live request
  assert property (@(posedge CLK) disable iff (RST) $rose(ack_key) |-> req_key);
  assert property (@(posedge CLK) disable iff (RST) $rose(ack_erase) |-> req_erase);

endmodule

/* source/dnc_vector_buffer.sv */
`timescale 1ns/1ns
`include "dnc_consts.svh"

module dnc_vector_buffer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 mem_we,
  input  dnc_pkg::buf_wr_t     mem_wr,
  input  dnc_pkg::dnc_addr_t   rd_addr,
  output dnc_pkg::dnc_data_t   rd_data
);

  import dnc_pkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Key region below, erase region above
  dnc_data_t mem [0:2*`DNC_W_MAX-1];

  // Single write port from the arbiter
  always_ff @(posedge CLK) begin
    if (mem_we) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Data one cycle after the address
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* source/dnc_write_interface.sv */
`timescale 1ns/1ns

module dnc_write_interface (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  key_start,
  input  logic                  erase_start,
  input  dnc_pkg::dnc_count_t   size_w,
  input  logic                  k_in_enable,
  input  dnc_pkg::dnc_data_t    k_in,
  output logic                  k_in_ack,
  output logic                  k_out_valid,
  output dnc_pkg::dnc_data_t    k_out,
  input  logic                  e_in_enable,
  input  dnc_pkg::dnc_data_t    e_in,
  output logic                  e_in_ack,
  output logic                  key_ready,
  output logic                  erase_ready,
  input  dnc_pkg::dnc_addr_t    rd_addr,
  output dnc_pkg::dnc_data_t    rd_data
);

  import dnc_pkg::*;

  //////////////////////////////
  // Buffer port wiring
  //////////////////////////////

  // Key writer to arbiter
  logic    key_req;
  logic    key_ack;
  buf_wr_t key_wr;

  // Erase writer to arbiter
  logic    erase_req;
  logic    erase_ack;
  buf_wr_t erase_wr;

  // Arbiter to memory
  logic    mem_we;
  buf_wr_t mem_wr;

  //////////////////////////////
  // Writers
  //////////////////////////////

  dnc_write_key u_write_key (
    .CLK         (CLK),
    .RST         (RST),
    .start       (key_start),
    .size_w      (size_w),
    .k_in_enable (k_in_enable),
    .k_in        (k_in),
    .k_in_ack    (k_in_ack),
    .k_out_valid (k_out_valid),
    .k_out       (k_out),
    .buf_req     (key_req),
    .buf_wr      (key_wr),
    .buf_ack     (key_ack),
    .ready       (key_ready)
  );

  dnc_erase_vector u_erase_vector (
    .CLK         (CLK),
    .RST         (RST),
    .start       (erase_start),
    .size_w      (size_w),
    .e_in_enable (e_in_enable),
    .e_in        (e_in),
    .e_in_ack    (e_in_ack),
    .buf_req     (erase_req),
    .buf_wr      (erase_wr),
    .buf_ack     (erase_ack),
    .ready       (erase_ready)
  );

  //////////////////////////////
  // Shared buffer
  //////////////////////////////

  dnc_buffer_arbiter u_buffer_arbiter (
    .CLK       (CLK),
    .RST       (RST),
    .req_key   (key_req),
    .req_erase (erase_req),
    .wr_key    (key_wr),
    .wr_erase  (erase_wr),
    .ack_key   (key_ack),
    .ack_erase (erase_ack),
    .mem_we    (mem_we),
    .mem_wr    (mem_wr)
  );

  dnc_vector_buffer u_vector_buffer (
    .CLK     (CLK),
    .RST     (RST),
    .mem_we  (mem_we),
    .mem_wr  (mem_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* verification/dnc_write_interface_tb.sv */
`timescale 1ns/1ns
`include "dnc_consts.svh"

module dnc_write_interface_tb;

  import dnc_pkg::*;

  //////////////////////////////
  // Test table types
  //////////////////////////////

  typedef enum logic [1:0] {KEY_ONLY, ERASE_ONLY, BOTH} start_mode_t;
  typedef enum logic {DATA_LFSR, DATA_EDGE} data_mode_t;

  typedef struct packed {
    dnc_count_t  size;
    start_mode_t start_mode;
    data_mode_t  data_mode;
  } test_row_t;

  localparam int NUM_TESTS  = 7;
  localparam int WAIT_LIMIT = 300;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic       CLK;
  logic       RST;
  logic       key_start;
  logic       erase_start;
  dnc_count_t size_w;
  logic       k_in_enable;
  dnc_data_t  k_in;
  logic       k_in_ack;
  logic       k_out_valid;
  dnc_data_t  k_out;
  logic       e_in_enable;
  dnc_data_t  e_in;
  logic       e_in_ack;
  logic       key_ready;
  logic       erase_ready;
  dnc_addr_t  rd_addr;
  dnc_data_t  rd_data;

  // Stimulus vectors and buffer model
  test_row_t   test_table [0:NUM_TESTS-1];
  dnc_data_t   key_vec [0:`DNC_W_MAX-1];
  dnc_data_t   erase_vec [0:`DNC_W_MAX-1];
  dnc_data_t   exp_mem [0:2*`DNC_W_MAX-1];
  bit          exp_valid [0:2*`DNC_W_MAX-1];
  logic [31:0] lfsr_state;

  // Monitor totals, running over the whole run
  dnc_data_t mirror_q [$];
  int        key_ready_total;
  int        erase_ready_total;

  int check_count;
  int error_count;
  int tests_failed;

  dnc_write_interface UUT (.*);

  always #20 CLK = ~CLK;

  // Outputs sampled mid-cycle where they are settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (k_out_valid) mirror_q.push_back(k_out);
      if (key_ready) key_ready_total++;
      if (erase_ready) erase_ready_total++;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    $display("Some tests failed");
    $finish;
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) lfsr_next = (s >> 1) ^ LFSR_TAPS;
    else lfsr_next = s >> 1;
  endfunction

  // One LFSR step per element bit
  task automatic draw_word(output dnc_data_t w);
    int b;
    w = '0;
    for (b = 0; b < `DNC_DATA_WIDTH; b++) begin
      w = {lfsr_state[0], w[`DNC_DATA_WIDTH-1:1]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Negative, zero, mid, one, just above one, extremes
  function automatic dnc_data_t edge_value(input int i);
    case (i % 8)
      0: edge_value = 32'hffff_0000;
      1: edge_value = 32'h0000_0000;
      2: edge_value = 32'h0000_8000;
      3: edge_value = `DNC_FX_ONE;
      4: edge_value = 32'h0001_0001;
      5: edge_value = 32'h7fff_ffff;
      6: edge_value = 32'h8000_0000;
      default: edge_value = 32'h0000_ffff;
    endcase
  endfunction

  // Erase weight saturated to [0, 1]
  function automatic dnc_data_t clamp_unit(input dnc_data_t v);
    if ($signed(v) < 0) clamp_unit = '0;
    else if ($signed(v) > $signed(`DNC_FX_ONE)) clamp_unit = `DNC_FX_ONE;
    else clamp_unit = v;
  endfunction

  function automatic string mode_name(input start_mode_t m);
    case (m)
      KEY_ONLY:   mode_name = "key";
      ERASE_ONLY: mode_name = "erase";
      default:    mode_name = "key+erase";
    endcase
  endfunction

  // Presents n elements, each held until acked
  task automatic feed_stream(input bit erase_side, input int n);
    int  i;
    int  t;
    bit  acked;
    for (i = 0; i < n; i++) begin
      if (erase_side) begin
        e_in        = erase_vec[i];
        e_in_enable = 1'b1;
      end else begin
        k_in        = key_vec[i];
        k_in_enable = 1'b1;
      end
      acked = 1'b0;
      t     = 0;
      while (!acked) begin
        @(negedge CLK);
        acked = erase_side ? e_in_ack : k_in_ack;
        if (!acked) begin
          t++;
          if (t >= WAIT_LIMIT) stop_on_timeout(erase_side ? "e_in_ack" : "k_in_ack");
        end
      end
      // Capture edge
      @(posedge CLK);
      #2;
    end
    if (erase_side) e_in_enable = 1'b0;
    else k_in_enable = 1'b0;
  endtask

  task automatic wait_readies(input bit need_key, input bit need_erase,
                              input int key_base, input int erase_base);
    int t;
    t = 0;
    while ((need_key && key_ready_total == key_base) ||
           (need_erase && erase_ready_total == erase_base)) begin
      @(negedge CLK);
      t++;
      if (t >= WAIT_LIMIT) stop_on_timeout("ready pulse");
    end
    @(posedge CLK);
    #2;
  endtask

  // Read port has one cycle of latency
  task automatic read_word(input int a, output dnc_data_t d);
    rd_addr = dnc_addr_t'(a);
    @(posedge CLK);
    @(negedge CLK);
    d = rd_data;
    @(posedge CLK);
    #2;
  endtask

  //////////////////////////////
  // One table row
  //////////////////////////////

  task automatic run_test(input int idx, input test_row_t row);
    int        n;
    int        i;
    int        a;
    int        errs_before;
    int        key_base;
    int        erase_base;
    int        mirror_base;
    bit        use_key;
    bit        use_erase;
    dnc_data_t got;
    n           = int'(row.size);
    use_key     = (row.start_mode != ERASE_ONLY);
    use_erase   = (row.start_mode != KEY_ONLY);
    errs_before = error_count;
    for (i = 0; i < n; i++) begin
      if (row.data_mode == DATA_LFSR) begin
        draw_word(key_vec[i]);
        draw_word(erase_vec[i]);
      end else begin
        key_vec[i]   = edge_value(i + 5);
        erase_vec[i] = edge_value(i);
      end
    end
    key_base    = key_ready_total;
    erase_base  = erase_ready_total;
    mirror_base = mirror_q.size();
    // Start strobe, one cycle
    size_w      = row.size;
    key_start   = use_key;
    erase_start = use_erase;
    @(posedge CLK);
    #2;
    key_start   = 1'b0;
    erase_start = 1'b0;
    fork
      if (use_key) feed_stream(1'b0, n);
      if (use_erase) feed_stream(1'b1, n);
    join
    wait_readies(use_key, use_erase, key_base, erase_base);
    for (i = 0; i < n; i++) begin
      if (use_key) begin
        exp_mem[`DNC_KEY_BASE + i]   = key_vec[i];
        exp_valid[`DNC_KEY_BASE + i] = 1'b1;
      end
      if (use_erase) begin
        exp_mem[`DNC_ERASE_BASE + i]   = clamp_unit(erase_vec[i]);
        exp_valid[`DNC_ERASE_BASE + i] = 1'b1;
      end
    end
    // Whole buffer, so a stray write shows up too
    for (a = 0; a < 2 * `DNC_W_MAX; a++) begin
      if (exp_valid[a]) begin
        read_word(a, got);
        check_value($sformatf("buffer addr %0d", a), got, exp_mem[a]);
      end
    end
    check_value("k_out count", 32'(mirror_q.size() - mirror_base), use_key ? 32'(n) : 32'd0);
    if (mirror_q.size() - mirror_base == (use_key ? n : 0)) begin
      for (i = 0; i < mirror_q.size() - mirror_base; i++) begin
        check_value($sformatf("k_out element %0d", i), mirror_q[mirror_base + i], key_vec[i]);
      end
    end
    check_value("key_ready pulses", 32'(key_ready_total - key_base), 32'(use_key));
    check_value("erase_ready pulses", 32'(erase_ready_total - erase_base), 32'(use_erase));
    if (error_count != errs_before) tests_failed++;
    $display("test %0d: %s stream, size_w %0d: %s", idx, mode_name(row.start_mode), n,
             (error_count == errs_before) ? "ok" : "FAILED");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    int k;
    CLK               = 1'b0;
    RST               = 1'b1;
    key_start         = 1'b0;
    erase_start       = 1'b0;
    size_w            = '0;
    k_in_enable       = 1'b0;
    k_in              = '0;
    e_in_enable       = 1'b0;
    e_in              = '0;
    rd_addr           = '0;
    lfsr_state        = 32'hccc4_819f;
    key_ready_total   = 0;
    erase_ready_total = 0;
    check_count       = 0;
    error_count       = 0;
    tests_failed      = 0;
    for (k = 0; k < 2 * `DNC_W_MAX; k++) exp_valid[k] = 1'b0;

    // Size edges 1 and 16 covered in later rows
    test_table[0] = '{dnc_count_t'(8), KEY_ONLY, DATA_LFSR};
    test_table[1] = '{dnc_count_t'(8), ERASE_ONLY, DATA_EDGE};
    test_table[2] = '{dnc_count_t'(10), BOTH, DATA_LFSR};
    test_table[3] = '{dnc_count_t'(1), BOTH, DATA_EDGE};
    test_table[4] = '{dnc_count_t'(16), BOTH, DATA_LFSR};
    test_table[5] = '{dnc_count_t'(16), ERASE_ONLY, DATA_LFSR};
    test_table[6] = '{dnc_count_t'(1), KEY_ONLY, DATA_LFSR};

    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    // Elements offered with no start, idle writers must not ack
    k_in_enable = 1'b1;
    e_in_enable = 1'b1;

    // Idle outputs after reset
    @(negedge CLK);
    check_value("key_ready after reset", 32'(key_ready), 32'd0);
    check_value("erase_ready after reset", 32'(erase_ready), 32'd0);
    check_value("k_out_valid after reset", 32'(k_out_valid), 32'd0);
    check_value("k_in_ack after reset", 32'(k_in_ack), 32'd0);
    check_value("e_in_ack after reset", 32'(e_in_ack), 32'd0);
    if (error_count != 0) tests_failed++;
    $display("reset check: %s", (error_count == 0) ? "ok" : "FAILED");
    @(posedge CLK);
    #2;
    k_in_enable = 1'b0;
    e_in_enable = 1'b0;

    for (k = 0; k < NUM_TESTS; k++) begin
      run_test(k, test_table[k]);
    end

    $display("%0d tests run, %0d with errors, %0d checks, %0d mismatches",
             NUM_TESTS + 1, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+source
source/dnc_pkg.sv
source/dnc_write_key.sv
source/dnc_erase_vector.sv
source/dnc_buffer_arbiter.sv
source/dnc_vector_buffer.sv
source/dnc_write_interface.sv
verification/dnc_write_interface_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DNC write front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f \
  --top-module dnc_write_interface_tb -o dnc_write_interface_tb

./obj_dir/dnc_write_interface_tb > sim.log
cat sim.log

# Verdict comes from the log
if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1
